//--- include/rgmii_hw_test_consts.svh
// Register map, Ethernet framing bytes and payload limits
`ifndef RGMII_HW_TEST_CONSTS_SVH
`define RGMII_HW_TEST_CONSTS_SVH

`define RHT_REG_CTRL      3'd0
`define RHT_REG_LEN       3'd1
`define RHT_REG_SEED      3'd2
`define RHT_REG_TX_COUNT  3'd3
`define RHT_REG_RX_GOOD   3'd4
`define RHT_REG_RX_BAD    3'd5
`define RHT_REG_RX_LEN    3'd6

`define RHT_PREAMBLE_LEN  16'd7
`define RHT_PREAMBLE_BYTE 8'h55
`define RHT_SFD_BYTE      8'hD5
`define RHT_IFG_CYCLES    16'd12
`define RHT_MIN_LEN       16'd1
`define RHT_MAX_LEN       16'd1500
// Reflected register value after data plus a correct FCS
`define RHT_CRC_RESIDUE   32'hDEBB20E3

`endif

//--- verilog/rgmii_hw_test_pkg.sv
// Vector types shared across the RGMII test core
// FSM state encodings for the frame generator and the frame checker
`default_nettype none

package rgmii_hw_test_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [3:0] nibble_t;
	typedef logic [2:0] reg_addr_t;
	typedef logic [15:0] reg_data_t;
	typedef logic [15:0] count_t;
	typedef logic [31:0] crc_t;

	typedef enum logic [2:0] {
		GEN_IDLE,
		GEN_PREAMBLE,
		GEN_SFD,
		GEN_PAYLOAD,
		GEN_FCS,
		GEN_GAP
	} gen_state_t;

	typedef enum logic [1:0] {
		CHK_IDLE,
		CHK_PREAMBLE,
		CHK_DATA,
		CHK_DROP
	} chk_state_t;

endpackage

`default_nettype wire

//--- verilog/crc32_engine.sv
// Byte-wide Ethernet CRC-32 accumulator, reflected form
`default_nettype none
`timescale 1ns/1ns

module crc32_engine (
	input wire clk,
	input wire rst_n,
	input wire clear,
	input wire enable,
	input wire rgmii_hw_test_pkg::byte_t data,
	output rgmii_hw_test_pkg::crc_t crc
);
	import rgmii_hw_test_pkg::*;

	// 0x04C11DB7 bit-reversed
	localparam crc_t POLY = 32'hEDB88320;

	// LSB-first fold of one byte
	function automatic crc_t fold_byte(input crc_t cur, input byte_t din);
		crc_t c;
		c = cur ^ {24'd0, din};
		for (int i = 0; i < 8; i++) begin
			c = c[0] ? ((c >> 1) ^ POLY) : (c >> 1);
		end
		return c;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n || clear) begin
			crc <= '1;
		end else if (enable) begin
			crc <= fold_byte(crc, data);
		end
	end

endmodule

`default_nettype wire

//--- verilog/frame_generator.sv
// Test frame generator on GMII
// Preamble, SFD, counting payload, CRC-32 FCS and inter-frame gap
`default_nettype none
`timescale 1ns/1ns
`include "rgmii_hw_test_consts.svh"

module frame_generator (
	input wire tx_clk,
	input wire rst_n,
	input wire start,
	input wire rgmii_hw_test_pkg::count_t payload_len,
	input wire rgmii_hw_test_pkg::byte_t seed,
	output logic busy,
	output logic frame_sent,
	output rgmii_hw_test_pkg::byte_t gmii_txd,
	output logic gmii_tx_en,
	output logic gmii_tx_er
);
	import rgmii_hw_test_pkg::*;

	gen_state_t state;
	count_t cnt;
	count_t len_q;
	byte_t seed_q;
	crc_t crc;
	crc_t fcs;
	logic len_ok;

	assign len_ok = (payload_len >= `RHT_MIN_LEN) && (payload_len <= `RHT_MAX_LEN);
	assign fcs = ~crc;

	crc32_engine crc_i (
		.clk(tx_clk),
		.rst_n,
		.clear(state == GEN_IDLE),
		.enable(state == GEN_PAYLOAD),
		.data(gmii_txd),
		.crc
	);

	// Sampled once when a frame is accepted
	always_ff @(posedge tx_clk) begin
		if (state == GEN_IDLE && start) begin
			len_q <= payload_len;
			seed_q <= seed;
		end
	end

	// cnt indexes the byte now on gmii_txd within the current state
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			state <= GEN_IDLE;
			cnt <= '0;
		end else begin
			cnt <= cnt + 16'd1;
			case (state)
			GEN_IDLE: begin
				cnt <= '0;
				if (start && len_ok) begin
					state <= GEN_PREAMBLE;
				end
			end
			GEN_PREAMBLE: begin
				if (cnt == `RHT_PREAMBLE_LEN - 16'd1) begin
					state <= GEN_SFD;
					cnt <= '0;
				end
			end
			GEN_SFD: begin
				state <= GEN_PAYLOAD;
				cnt <= '0;
			end
			GEN_PAYLOAD: begin
				if (cnt == len_q - 16'd1) begin
					state <= GEN_FCS;
					cnt <= '0;
				end
			end
			GEN_FCS: begin
				if (cnt == 16'd3) begin
					state <= GEN_GAP;
					cnt <= '0;
				end
			end
			default: begin
				if (cnt == `RHT_IFG_CYCLES - 16'd1) begin
					state <= GEN_IDLE;
					cnt <= '0;
				end
			end
			endcase
		end
	end

	always_comb begin
		case (state)
		GEN_PREAMBLE: gmii_txd = `RHT_PREAMBLE_BYTE;
		GEN_SFD:      gmii_txd = `RHT_SFD_BYTE;
		GEN_PAYLOAD:  gmii_txd = seed_q + cnt[7:0];
		// FCS goes out low byte first
		GEN_FCS:      gmii_txd = fcs[{cnt[1:0], 3'b000} +: 8];
		default:      gmii_txd = 8'h00;
		endcase
	end

	assign gmii_tx_en = state inside {GEN_PREAMBLE, GEN_SFD, GEN_PAYLOAD, GEN_FCS};
	assign gmii_tx_er = 1'b0;
	assign busy = (state != GEN_IDLE);
	assign frame_sent = (state == GEN_FCS) && (cnt == 16'd3);

endmodule

`default_nettype wire

//--- verilog/gmii_to_rgmii.sv
// GMII to RGMII double-data-rate conversion on one clock
// Transmit nibble mux by clock phase, receive capture on both edges
`default_nettype none
`timescale 1ns/1ns

module gmii_to_rgmii (
	input wire tx_clk,
	input wire rst_n,
	input wire rgmii_hw_test_pkg::byte_t gmii_txd,
	input wire gmii_tx_en,
	input wire gmii_tx_er,
	output rgmii_hw_test_pkg::byte_t gmii_rxd,
	output logic gmii_rx_dv,
	output logic gmii_rx_er,
	output rgmii_hw_test_pkg::nibble_t rgmii_txd,
	output logic rgmii_tx_ctl,
	output logic rgmii_tx_clk,
	input wire rgmii_hw_test_pkg::nibble_t rgmii_rxd,
	input wire rgmii_rx_ctl
);
	import rgmii_hw_test_pkg::*;

	byte_t txd_q;
	logic tx_en_q;
	logic tx_er_q;
	nibble_t rx_lo;
	logic rx_dv_lo;

	always_ff @(posedge tx_clk) begin
		txd_q <= gmii_txd;
		if (!rst_n) begin
			tx_en_q <= 1'b0;
			tx_er_q <= 1'b0;
		end else begin
			tx_en_q <= gmii_tx_en;
			tx_er_q <= gmii_tx_er;
		end
	end

	// High phase carries low nibble and tx_en, low phase the rest
	assign rgmii_tx_clk = tx_clk;
	assign rgmii_txd = tx_clk ? txd_q[3:0] : txd_q[7:4];
	assign rgmii_tx_ctl = tx_clk ? tx_en_q : (tx_en_q ^ tx_er_q);

	// Low half and dv close with the high phase
	always_ff @(negedge tx_clk) begin
		rx_lo <= rgmii_rxd;
		if (!rst_n) begin
			rx_dv_lo <= 1'b0;
		end else begin
			rx_dv_lo <= rgmii_rx_ctl;
		end
	end

	// High half closes with the low phase, byte complete here
	always_ff @(posedge tx_clk) begin
		gmii_rxd <= {rgmii_rxd, rx_lo};
		if (!rst_n) begin
			gmii_rx_dv <= 1'b0;
			gmii_rx_er <= 1'b0;
		end else begin
			gmii_rx_dv <= rx_dv_lo;
			gmii_rx_er <= rx_dv_lo ^ rgmii_rx_ctl;
		end
	end

endmodule

`default_nettype wire

//--- verilog/frame_checker.sv
// Receive frame checker on GMII
// SFD search, FCS residue check, good/bad counters and last length
`default_nettype none
`timescale 1ns/1ns
`include "rgmii_hw_test_consts.svh"

module frame_checker (
	input wire tx_clk,
	input wire rst_n,
	input wire rgmii_hw_test_pkg::byte_t gmii_rxd,
	input wire gmii_rx_dv,
	input wire gmii_rx_er,
	output rgmii_hw_test_pkg::count_t rx_good,
	output rgmii_hw_test_pkg::count_t rx_bad,
	output rgmii_hw_test_pkg::count_t rx_len,
	output logic frame_done
);
	import rgmii_hw_test_pkg::*;

	// Shortest acceptable tail: one payload byte plus FCS
	localparam count_t MIN_AFTER_SFD = 16'd5;

	chk_state_t state;
	count_t byte_cnt;
	logic er_seen;
	logic frame_ok;
	crc_t crc;

	function automatic count_t sat_inc(input count_t v);
		return (v == '1) ? v : v + 16'd1;
	endfunction

	crc32_engine crc_i (
		.clk(tx_clk),
		.rst_n,
		.clear(state != CHK_DATA),
		.enable((state == CHK_DATA) && gmii_rx_dv),
		.data(gmii_rxd),
		.crc
	);

	assign frame_ok = !er_seen && (byte_cnt >= MIN_AFTER_SFD) && (crc == `RHT_CRC_RESIDUE);

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			state <= CHK_IDLE;
			byte_cnt <= '0;
			er_seen <= 1'b0;
			rx_good <= '0;
			rx_bad <= '0;
			rx_len <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (gmii_rx_dv && gmii_rx_er) begin
				er_seen <= 1'b1;
			end
			case (state)
			CHK_IDLE: begin
				er_seen <= gmii_rx_dv && gmii_rx_er;
				byte_cnt <= '0;
				if (gmii_rx_dv) begin
					state <= (gmii_rxd == `RHT_SFD_BYTE) ? CHK_DATA : CHK_PREAMBLE;
				end
			end
			CHK_PREAMBLE: begin
				if (!gmii_rx_dv) begin
					// Carrier dropped before any SFD
					rx_bad <= sat_inc(rx_bad);
					frame_done <= 1'b1;
					state <= CHK_IDLE;
				end else if (gmii_rxd == `RHT_SFD_BYTE) begin
					state <= CHK_DATA;
				end else if (gmii_rxd != `RHT_PREAMBLE_BYTE) begin
					state <= CHK_DROP;
				end
			end
			CHK_DATA: begin
				if (gmii_rx_dv) begin
					byte_cnt <= byte_cnt + 16'd1;
				end else begin
					rx_len <= byte_cnt;
					if (frame_ok) begin
						rx_good <= sat_inc(rx_good);
					end else begin
						rx_bad <= sat_inc(rx_bad);
					end
					frame_done <= 1'b1;
					state <= CHK_IDLE;
				end
			end
			default: begin
				if (!gmii_rx_dv) begin
					rx_bad <= sat_inc(rx_bad);
					frame_done <= 1'b1;
					state <= CHK_IDLE;
				end
			end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/hw_test_regs.sv
// Wishbone classic register file for the test core
// Start pulse, PHY reset, frame parameters, counters and LEDs
`default_nettype none
`timescale 1ns/1ns
`include "rgmii_hw_test_consts.svh"

module hw_test_regs (
	input wire tx_clk,
	input wire rst_n,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire rgmii_hw_test_pkg::reg_addr_t wb_adr,
	input wire rgmii_hw_test_pkg::reg_data_t wb_dat_w,
	output rgmii_hw_test_pkg::reg_data_t wb_dat_r,
	output logic wb_ack,
	input wire busy,
	input wire frame_sent,
	input wire rgmii_hw_test_pkg::count_t rx_good,
	input wire rgmii_hw_test_pkg::count_t rx_bad,
	input wire rgmii_hw_test_pkg::count_t rx_len,
	input wire frame_done,
	output logic start,
	output rgmii_hw_test_pkg::count_t payload_len,
	output rgmii_hw_test_pkg::byte_t seed,
	output logic phy_rstn,
	output logic [3:0] led
);
	import rgmii_hw_test_pkg::*;

	logic wr_en;
	count_t tx_count;
	count_t good_seen;
	logic last_good;
	logic last_bad;

	// Writes land on the ack cycle
	assign wr_en = wb_ack && wb_cyc && wb_stb && wb_we;
	assign start = wr_en && (wb_adr == `RHT_REG_CTRL) && wb_dat_w[0];

	// Single-cycle ack, never back to back
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= wb_cyc && wb_stb && !wb_ack;
		end
	end

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			phy_rstn <= 1'b0;
			payload_len <= '0;
			seed <= '0;
		end else if (wr_en) begin
			case (wb_adr)
			`RHT_REG_CTRL: phy_rstn <= wb_dat_w[1];
			`RHT_REG_LEN:  payload_len <= wb_dat_w;
			`RHT_REG_SEED: seed <= wb_dat_w[7:0];
			default: ;
			endcase
		end
	end

	// Good vs bad told apart by whether rx_good moved
	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			tx_count <= '0;
			good_seen <= '0;
			last_good <= 1'b0;
			last_bad <= 1'b0;
		end else begin
			if (frame_sent) begin
				tx_count <= tx_count + 16'd1;
			end
			if (frame_done) begin
				good_seen <= rx_good;
				last_good <= (rx_good != good_seen);
				last_bad <= (rx_good == good_seen);
			end
		end
	end

	always_comb begin
		case (wb_adr)
		`RHT_REG_CTRL:     wb_dat_r = {14'd0, phy_rstn, busy};
		`RHT_REG_LEN:      wb_dat_r = payload_len;
		`RHT_REG_SEED:     wb_dat_r = {8'd0, seed};
		`RHT_REG_TX_COUNT: wb_dat_r = tx_count;
		`RHT_REG_RX_GOOD:  wb_dat_r = rx_good;
		`RHT_REG_RX_BAD:   wb_dat_r = rx_bad;
		`RHT_REG_RX_LEN:   wb_dat_r = rx_len;
		default:           wb_dat_r = '0;
		endcase
	end

	assign led = {phy_rstn, last_bad, last_good, busy};

endmodule

`default_nettype wire

//--- verilog/rgmii_hw_test.sv
// RGMII hardware test core, top level
// Registers, frame generator, frame checker and DDR converter
`default_nettype none
`timescale 1ns/1ns

module rgmii_hw_test (
	input wire tx_clk,
	input wire rst_n,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire rgmii_hw_test_pkg::reg_addr_t wb_adr,
	input wire rgmii_hw_test_pkg::reg_data_t wb_dat_w,
	output rgmii_hw_test_pkg::reg_data_t wb_dat_r,
	output logic wb_ack,
	output rgmii_hw_test_pkg::nibble_t rgmii_txd,
	output logic rgmii_tx_ctl,
	output logic rgmii_tx_clk,
	input wire rgmii_hw_test_pkg::nibble_t rgmii_rxd,
	input wire rgmii_rx_ctl,
	output logic phy_rstn,
	output logic [3:0] led
);
	import rgmii_hw_test_pkg::*;

	logic start, busy, frame_sent, frame_done;
	count_t payload_len, rx_good, rx_bad, rx_len;
	byte_t seed, gmii_txd, gmii_rxd;
	logic gmii_tx_en, gmii_tx_er, gmii_rx_dv, gmii_rx_er;

	hw_test_regs regs (
		.tx_clk, .rst_n,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.busy, .frame_sent, .rx_good, .rx_bad, .rx_len, .frame_done,
		.start, .payload_len, .seed, .phy_rstn, .led
	);

	frame_generator gen (
		.tx_clk, .rst_n, .start, .payload_len, .seed, .busy, .frame_sent,
		.gmii_txd, .gmii_tx_en, .gmii_tx_er
	);

	// Receive side runs on tx_clk as well
	gmii_to_rgmii ddr (
		.tx_clk, .rst_n,
		.gmii_txd, .gmii_tx_en, .gmii_tx_er,
		.gmii_rxd, .gmii_rx_dv, .gmii_rx_er,
		.rgmii_txd, .rgmii_tx_ctl, .rgmii_tx_clk,
		.rgmii_rxd, .rgmii_rx_ctl
	);

	frame_checker chk (
		.tx_clk, .rst_n, .gmii_rxd, .gmii_rx_dv, .gmii_rx_er,
		.rx_good, .rx_bad, .rx_len, .frame_done
	);

endmodule

`default_nettype wire

//--- tests/rgmii_hw_test_asserts.sv
// Bound protocol assertions for the Wishbone port, RGMII transmit control and PHY reset
`default_nettype none
`timescale 1ns/1ns
`include "rgmii_hw_test_consts.svh"

module rgmii_hw_test_asserts (
	input wire tx_clk,
	input wire rst_n,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire rgmii_hw_test_pkg::reg_addr_t wb_adr,
	input wire rgmii_hw_test_pkg::reg_data_t wb_dat_w,
	input wire wb_ack,
	input wire start,
	input wire rgmii_tx_ctl,
	input wire phy_rstn
);

	int unsigned fail_ack = 0;
	int unsigned fail_ctl_rise = 0;
	int unsigned fail_ctl_fall = 0;
	int unsigned fail_phy = 0;
	logic started;
	logic released;

	always_ff @(posedge tx_clk) begin
		if (!rst_n) begin
			started <= 1'b0;
			released <= 1'b0;
		end else begin
			if (start) begin
				started <= 1'b1;
			end
			if (wb_ack && wb_cyc && wb_stb && wb_we && wb_adr == `RHT_REG_CTRL && wb_dat_w[1]) begin
				released <= 1'b1;
			end
		end
	end

	ack_needs_stb: assert property (@(posedge tx_clk) disable iff (!rst_n) wb_ack |-> wb_stb)
		else begin
			fail_ack = fail_ack + 1;
			$error("wb_ack high without wb_stb");
		end

	// Rising edge samples the low phase, falling edge the high phase
	ctl_quiet_rise: assert property (@(posedge tx_clk) disable iff (!rst_n)
		!started |-> !rgmii_tx_ctl)
		else begin
			fail_ctl_rise = fail_ctl_rise + 1;
			$error("rgmii_tx_ctl high in low phase before any start");
		end

	ctl_quiet_fall: assert property (@(negedge tx_clk) disable iff (!rst_n)
		!started |-> !rgmii_tx_ctl)
		else begin
			fail_ctl_fall = fail_ctl_fall + 1;
			$error("rgmii_tx_ctl high in high phase before any start");
		end

	phy_held: assert property (@(posedge tx_clk) disable iff (!rst_n) !released |-> !phy_rstn)
		else begin
			fail_phy = fail_phy + 1;
			$error("phy_rstn released without a CTRL bit 1 write");
		end

endmodule

bind rgmii_hw_test rgmii_hw_test_asserts asrt (
	.tx_clk, .rst_n,
	.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_ack,
	.start, .rgmii_tx_ctl, .phy_rstn
);

`default_nettype wire

//--- tests/rgmii_hw_test_tb.sv
// Directed testbench for the RGMII test core
// RGMII loopback with fault injection, Wishbone access tasks and result checks
`default_nettype none
`timescale 1ns/1ns
`include "rgmii_hw_test_consts.svh"

module rgmii_hw_test_tb;
	import rgmii_hw_test_pkg::*;

	localparam int ACK_TIMEOUT = 16;
	// Each poll is one Wishbone read of about three cycles
	localparam int POLL_LIMIT = 1200;

	logic tx_clk = 1'b0;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	reg_addr_t wb_adr;
	reg_data_t wb_dat_w;
	reg_data_t wb_dat_r;
	logic wb_ack;
	nibble_t rgmii_txd;
	logic rgmii_tx_ctl;
	logic rgmii_tx_clk;
	nibble_t rgmii_rxd = '0;
	logic rgmii_rx_ctl = 1'b0;
	logic phy_rstn;
	logic [3:0] led;

	// Payload byte index to corrupt, -1 for none
	int flip_byte = -1;
	int err_byte = -1;
	int wire_idx = -1;
	int wire_cnt = 0;
	nibble_t tx_lo = '0;
	// Payload length and first byte of the frame in flight
	int frame_len = 0;
	byte_t frame_seed = '0;
	int errors = 0;
	int checks = 0;
	int exp_tx = 0;
	int exp_good = 0;
	int exp_bad = 0;
	logic phy_on = 1'b0;

	rgmii_hw_test uut (
		.tx_clk, .rst_n,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.rgmii_txd, .rgmii_tx_ctl, .rgmii_tx_clk,
		.rgmii_rxd, .rgmii_rx_ctl,
		.phy_rstn, .led
	);

	always #5 tx_clk = ~tx_clk;

	// Loopback with a short board delay after each clock edge
	always begin
		@(posedge tx_clk);
		#2;
		if (rgmii_tx_ctl) begin
			wire_idx = wire_cnt;
			wire_cnt = wire_cnt + 1;
		end else begin
			wire_idx = -1;
			wire_cnt = 0;
		end
		tx_lo = rgmii_txd;
		// Preamble and SFD take wire bytes 0 to 7
		rgmii_rxd <= (flip_byte >= 0 && wire_idx == flip_byte + 8) ?
			(rgmii_txd ^ 4'h1) : rgmii_txd;
		rgmii_rx_ctl <= rgmii_tx_ctl;
		@(negedge tx_clk);
		#2;
		rgmii_rxd <= rgmii_txd;
		// Inverted low-phase control means tx_er
		rgmii_rx_ctl <= (err_byte >= 0 && wire_idx == err_byte + 8) ?
			!rgmii_tx_ctl : rgmii_tx_ctl;
		// FCS bytes are left to the checker
		if (wire_idx >= 0 && wire_idx < frame_len + 8) begin
			check_byte("rgmii_txd", {rgmii_txd, tx_lo}, wire_byte(wire_idx, frame_seed));
		end
	end

	// Preamble, SFD, then payload counting up from the seed
	function automatic byte_t wire_byte(input int idx, input byte_t sd);
		if (idx < `RHT_PREAMBLE_LEN) begin
			return `RHT_PREAMBLE_BYTE;
		end else if (idx == `RHT_PREAMBLE_LEN) begin
			return `RHT_SFD_BYTE;
		end
		return sd + byte_t'(idx - 8);
	endfunction

	function automatic string reg_name(input int a);
		case (a)
		0: return "CTRL";
		1: return "LEN";
		2: return "SEED";
		3: return "TX_COUNT";
		4: return "RX_GOOD";
		5: return "RX_BAD";
		6: return "RX_LEN";
		default: return "UNUSED";
		endcase
	endfunction

	task automatic check_reg(input string name, input reg_data_t got, input reg_data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got 0x%h expected 0x%h", $time, name, got, exp);
		end
	endtask

	task automatic check_led(input string name, input logic [3:0] got, input logic [3:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// One classic cycle, ack and read data sampled mid-cycle
	task automatic wb_access(input logic we, input reg_addr_t adr, input reg_data_t dat_w,
			output reg_data_t dat_r);
		int waited;
		waited = 0;
		@(posedge tx_clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_dat_w <= dat_w;
		@(negedge tx_clk);
		while (!wb_ack && waited < ACK_TIMEOUT) begin
			@(negedge tx_clk);
			waited++;
		end
		dat_r = wb_dat_r;
		if (!wb_ack) begin
			errors++;
			$display("Error at %0t: no wb_ack for access to address %0d", $time, adr);
		end
		@(posedge tx_clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic wb_write(input reg_addr_t adr, input reg_data_t dat);
		reg_data_t unused_rd;
		wb_access(1'b1, adr, dat, unused_rd);
	endtask

	task automatic wb_read(input reg_addr_t adr, output reg_data_t dat);
		wb_access(1'b0, adr, '0, dat);
	endtask

	task automatic read_reg(input reg_addr_t adr, input string name, input reg_data_t exp);
		reg_data_t v;
		wb_read(adr, v);
		check_reg(name, v, exp);
	endtask

	task automatic read_count(input reg_addr_t adr, input string name, input int exp);
		reg_data_t v;
		wb_read(adr, v);
		check_count(name, count_t'(v), count_t'(exp));
	endtask

	task automatic wait_for_reg(input reg_addr_t adr, input string name, input reg_data_t exp);
		reg_data_t v;
		int polls;
		polls = 0;
		wb_read(adr, v);
		while (v !== exp && polls < POLL_LIMIT) begin
			wb_read(adr, v);
			polls++;
		end
		if (v !== exp) begin
			errors++;
			$display("Error at %0t: timed out waiting for %s to read 0x%h", $time, name, exp);
		end
	endtask

	// Generator idle, busy bit clear
	task automatic wait_idle();
		wait_for_reg(`RHT_REG_CTRL, "CTRL", {14'd0, phy_on, 1'b0});
	endtask

	task automatic expect_led(input logic [3:0] exp);
		@(negedge tx_clk);
		check_led("led", led, exp);
	endtask

	task automatic expect_phy(input logic exp);
		@(negedge tx_clk);
		check_bit("phy_rstn", phy_rstn, exp);
	endtask

	// Forwarded clock follows tx_clk in both phases
	task automatic expect_clk_forward();
		@(posedge tx_clk);
		#2;
		check_bit("rgmii_tx_clk", rgmii_tx_clk, 1'b1);
		@(negedge tx_clk);
		#2;
		check_bit("rgmii_tx_clk", rgmii_tx_clk, 1'b0);
	endtask

	task automatic send_frame(input int len, input byte_t sd);
		frame_len = len;
		frame_seed = sd;
		wb_write(`RHT_REG_LEN, reg_data_t'(len));
		wb_write(`RHT_REG_SEED, {8'd0, sd});
		wb_write(`RHT_REG_CTRL, {14'd0, phy_on, 1'b1});
	endtask

	// Received length covers payload plus the 4 FCS bytes
	task automatic check_counters(input int len);
		read_count(`RHT_REG_TX_COUNT, "TX_COUNT", exp_tx);
		read_count(`RHT_REG_RX_GOOD, "RX_GOOD", exp_good);
		read_count(`RHT_REG_RX_BAD, "RX_BAD", exp_bad);
		read_count(`RHT_REG_RX_LEN, "RX_LEN", len + 4);
	endtask

	task automatic report_test(input string name, input int e0);
		$display("[%0t] %s: %0d errors", $time, name, errors - e0);
	endtask

	task automatic test_reset_values();
		int e0;
		int a;
		reg_data_t v;
		reg_data_t len_w;
		byte_t sd;
		e0 = errors;
		for (a = 0; a < 8; a++) begin
			wb_read(reg_addr_t'(a), v);
			check_reg(reg_name(a), v, 16'h0000);
		end
		len_w = reg_data_t'($urandom);
		sd = byte_t'($urandom);
		wb_write(`RHT_REG_LEN, len_w);
		wb_write(`RHT_REG_SEED, {8'd0, sd});
		read_reg(`RHT_REG_LEN, "LEN", len_w);
		read_reg(`RHT_REG_SEED, "SEED", {8'd0, sd});
		// Counters are read only
		for (a = 3; a < 7; a++) begin
			wb_write(reg_addr_t'(a), 16'hFFFF);
			wb_read(reg_addr_t'(a), v);
			check_reg(reg_name(a), v, 16'h0000);
		end
		expect_led(4'b0000);
		expect_phy(1'b0);
		expect_clk_forward();
		report_test("reset and register access", e0);
	endtask

	task automatic test_good_frame();
		int e0;
		int len;
		e0 = errors;
		len = int'($urandom_range(1, 1500));
		send_frame(len, byte_t'($urandom));
		exp_tx++;
		exp_good++;
		wait_for_reg(`RHT_REG_RX_GOOD, "RX_GOOD", reg_data_t'(exp_good));
		wait_idle();
		check_counters(len);
		expect_led(4'b0010);
		report_test("good frame loopback", e0);
	endtask

	task automatic test_flipped_nibble();
		int e0;
		int len;
		e0 = errors;
		len = int'($urandom_range(8, 200));
		flip_byte = int'($urandom_range(0, len - 1));
		send_frame(len, byte_t'($urandom));
		exp_tx++;
		exp_bad++;
		wait_for_reg(`RHT_REG_RX_BAD, "RX_BAD", reg_data_t'(exp_bad));
		flip_byte = -1;
		wait_idle();
		check_counters(len);
		expect_led(4'b0100);
		report_test("flipped payload nibble", e0);
	endtask

	task automatic test_rx_error();
		int e0;
		int len;
		e0 = errors;
		len = int'($urandom_range(8, 200));
		err_byte = int'($urandom_range(0, len - 1));
		send_frame(len, byte_t'($urandom));
		exp_tx++;
		exp_bad++;
		wait_for_reg(`RHT_REG_RX_BAD, "RX_BAD", reg_data_t'(exp_bad));
		err_byte = -1;
		wait_idle();
		check_counters(len);
		expect_led(4'b0100);
		report_test("receive error in payload", e0);
	endtask

	task automatic test_dropped_starts();
		int e0;
		int len;
		e0 = errors;
		len = int'($urandom_range(50, 300));
		send_frame(len, byte_t'($urandom));
		exp_tx++;
		exp_good++;
		read_reg(`RHT_REG_CTRL, "CTRL", 16'h0001);
		// Lands mid-frame
		wb_write(`RHT_REG_CTRL, 16'h0001);
		wait_for_reg(`RHT_REG_RX_GOOD, "RX_GOOD", reg_data_t'(exp_good));
		wait_idle();
		check_counters(len);
		wb_write(`RHT_REG_LEN, 16'h0000);
		wb_write(`RHT_REG_CTRL, 16'h0001);
		read_reg(`RHT_REG_CTRL, "CTRL", 16'h0000);
		// Longer than a minimum frame would stay busy
		repeat (32) @(posedge tx_clk);
		read_count(`RHT_REG_TX_COUNT, "TX_COUNT", exp_tx);
		read_reg(`RHT_REG_CTRL, "CTRL", 16'h0000);
		report_test("dropped starts", e0);
	endtask

	task automatic test_phy_and_burst();
		int e0;
		int i;
		int lens[3];
		e0 = errors;
		wb_write(`RHT_REG_CTRL, 16'h0002);
		phy_on = 1'b1;
		expect_phy(1'b1);
		read_reg(`RHT_REG_CTRL, "CTRL", 16'h0002);
		expect_led(4'b1010);
		lens[0] = int'($urandom_range(1, 100));
		lens[1] = int'($urandom_range(101, 400));
		lens[2] = int'($urandom_range(401, 800));
		for (i = 0; i < 3; i++) begin
			send_frame(lens[i], byte_t'($urandom));
			wait_idle();
		end
		exp_tx += 3;
		exp_good += 3;
		wait_for_reg(`RHT_REG_RX_GOOD, "RX_GOOD", reg_data_t'(exp_good));
		check_counters(lens[2]);
		expect_led(4'b1010);
		report_test("PHY release and three frames", e0);
	endtask

	initial begin
		int asrt_fails;
		void'($urandom(67539));
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (2) @(posedge tx_clk);
		rst_n <= 1'b1;

		test_reset_values();
		test_good_frame();
		test_flipped_nibble();
		test_rx_error();
		test_dropped_starts();
		test_phy_and_burst();

		asrt_fails = int'(uut.asrt.fail_ack + uut.asrt.fail_ctl_rise +
			uut.asrt.fail_ctl_fall + uut.asrt.fail_phy);
		$display("Totals: %0d checks, %0d errors, %0d assertion failures",
			checks, errors, asrt_fails);
		if (errors == 0 && asrt_fails == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rgmii_hw_test.f
+incdir+include
verilog/rgmii_hw_test_pkg.sv
verilog/crc32_engine.sv
verilog/frame_generator.sv
verilog/gmii_to_rgmii.sv
verilog/frame_checker.sv
verilog/hw_test_regs.sv
verilog/rgmii_hw_test.sv
tests/rgmii_hw_test_asserts.sv
tests/rgmii_hw_test_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= rgmii_hw_test_tb
FILELIST ?= rgmii_hw_test.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ns -j 0
SIM_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
